//--- hdl/wb_pkg.sv
package wb_pkg;

    ////////////////////
    // widths
    ////////////////////

    // data and address width
    localparam int WORD_W = 32;

    // general purpose register number
    localparam int REG_NUM_W = 5;

    ////////////////////
    // load formatting
    ////////////////////

    // load_none marks a non-load, result comes from the memory stage
    typedef enum logic [2:0] {
        LOAD_NONE = 3'd0,
        LOAD_LB   = 3'd1,
        LOAD_LBU  = 3'd2,
        LOAD_LH   = 3'd3,
        LOAD_LHU  = 3'd4,
        LOAD_LW   = 3'd5,
        LOAD_LWL  = 3'd6,
        LOAD_LWR  = 3'd7
    } load_op_e;

    ////////////////////
    // stage occupancy
    ////////////////////

    typedef enum logic {
        STAGE_EMPTY = 1'b0,
        STAGE_FULL  = 1'b1
    } wb_state_e;

endpackage

//--- hdl/wb_stage_if.sv
`timescale 1ns/1ps

// latched write-back fields, one instruction at a time
interface wb_stage_if;

    logic                          valid;
    logic [wb_pkg::REG_NUM_W-1:0]  write_num;
    logic                          mem_req;
    wb_pkg::load_op_e              load_op;
    logic [wb_pkg::WORD_W-1:0]     vaddr;
    logic [wb_pkg::WORD_W-1:0]     rt_data;
    logic [wb_pkg::WORD_W-1:0]     final_res;

    // stage register side
    modport producer (
        output valid,
        output write_num,
        output mem_req,
        output load_op,
        output vaddr,
        output rt_data,
        output final_res
    );

    // formatter and trace side
    modport consumer (
        input valid,
        input write_num,
        input mem_req,
        input load_op,
        input vaddr,
        input rt_data,
        input final_res
    );

endinterface

//--- hdl/wb_ctrl.sv
`timescale 1ns/1ps

module wb_ctrl (
    input  logic clk,
    input  logic rst,
    input  logic mem_valid_i,
    input  logic pipe_go_i,
    input  logic flush_i,
    output logic allowin_o,
    output logic load_o,
    output logic full_o,
    output logic commit_o
);

    wb_pkg::wb_state_e state_q;
    wb_pkg::wb_state_e state_d;

    ////////////////////
    // interlock
    ////////////////////

    assign full_o    = (state_q == wb_pkg::STAGE_FULL);
    assign allowin_o = pipe_go_i || !full_o;

    // flush beats both accept and commit
    assign load_o   = allowin_o && mem_valid_i && !flush_i;
    assign commit_o = full_o && pipe_go_i && !flush_i;

    ////////////////////
    // occupancy FSM
    ////////////////////

    always_comb begin
        state_d = state_q;
        if (flush_i) begin
            state_d = wb_pkg::STAGE_EMPTY;
        end else if (load_o) begin
            // covers commit and accept on the same edge
            state_d = wb_pkg::STAGE_FULL;
        end else if (commit_o) begin
            state_d = wb_pkg::STAGE_EMPTY;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            state_q <= wb_pkg::STAGE_EMPTY;
        end else begin
            state_q <= state_d;
        end
    end

    // nothing to retire from an empty stage
    a_no_commit_empty: assert property (@(posedge clk) disable iff (!rst)
        (state_q == wb_pkg::STAGE_EMPTY) |-> !commit_o);

    // a stalled stage keeps its instruction
    a_stall_holds: assert property (@(posedge clk) disable iff (!rst)
        (full_o && !pipe_go_i && !flush_i) |=> full_o);

endmodule

//--- hdl/wb_stage_reg.sv
`timescale 1ns/1ps

module wb_stage_reg (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          load_i,
    input  logic                          full_i,
    input  logic [wb_pkg::REG_NUM_W-1:0]  mem_write_num_i,
    input  logic                          mem_req_i,
    input  wb_pkg::load_op_e              mem_load_op_i,
    input  logic [wb_pkg::WORD_W-1:0]     mem_vaddr_i,
    input  logic [wb_pkg::WORD_W-1:0]     mem_rt_data_i,
    input  logic [wb_pkg::WORD_W-1:0]     mem_final_res_i,
    wb_stage_if.producer                  stage
);

    ////////////////////
    // control fields
    ////////////////////

    always_ff @(posedge clk) begin
        if (!rst) begin
            stage.write_num <= '0;
            stage.mem_req   <= 1'b0;
            stage.load_op   <= wb_pkg::LOAD_NONE;
        end else if (load_i) begin
            stage.write_num <= mem_write_num_i;
            stage.mem_req   <= mem_req_i;
            stage.load_op   <= mem_load_op_i;
        end
    end

    ////////////////////
    // payload
    ////////////////////

    always_ff @(posedge clk) begin
        if (load_i) begin
            stage.vaddr     <= mem_vaddr_i;
            stage.rt_data   <= mem_rt_data_i;
            stage.final_res <= mem_final_res_i;
        end
    end

    // occupancy comes straight from the controller
    assign stage.valid = full_i;

    // a load opcode must always come with a bus request
    a_load_has_req: assert property (@(posedge clk) disable iff (!rst)
        (load_i && mem_load_op_i != wb_pkg::LOAD_NONE) |=> stage.mem_req);

endmodule

//--- hdl/load_align.sv
`timescale 1ns/1ps

module load_align (
    wb_stage_if.consumer                stage,
    input  logic [wb_pkg::WORD_W-1:0]   data_rdata_i,
    output logic [wb_pkg::WORD_W-1:0]   result_o,
    output logic [wb_pkg::WORD_W-1:0]   fwd_data_o
);

    logic [1:0]                  offset;
    logic [4:0]                  lane_shift;
    logic [4:0]                  lwl_shift;
    logic [7:0]                  byte_lane;
    logic [15:0]                 half_lane;
    logic [wb_pkg::WORD_W-1:0]   lwl_data;
    logic [wb_pkg::WORD_W-1:0]   lwr_data;

    ////////////////////
    // lane selection
    ////////////////////

    assign offset     = stage.vaddr[1:0];
    // byte k sits at bit 8k
    assign lane_shift = {offset, 3'b000};
    // (3 - k) * 8
    assign lwl_shift  = {~offset, 3'b000};

    assign byte_lane = data_rdata_i[lane_shift +: 8];
    assign half_lane = offset[1] ? data_rdata_i[31:16] : data_rdata_i[15:0];

    ////////////////////
    // unaligned merge
    ////////////////////

    // lwl: low k+1 bus bytes go to the top, low rt bytes stay below
    assign lwl_data = (data_rdata_i << lwl_shift)
                    | (stage.rt_data & ~({wb_pkg::WORD_W{1'b1}} << lwl_shift));

    // lwr: bus bytes from k upward go to the bottom, high rt bytes stay above
    assign lwr_data = (data_rdata_i >> lane_shift)
                    | (stage.rt_data & ~({wb_pkg::WORD_W{1'b1}} >> lane_shift));

    ////////////////////
    // result select
    ////////////////////

    always_comb begin
        result_o = stage.final_res;
        if (stage.mem_req) begin
            case (stage.load_op)
                wb_pkg::LOAD_LB:  result_o = {{24{byte_lane[7]}}, byte_lane};
                wb_pkg::LOAD_LBU: result_o = {24'd0, byte_lane};
                wb_pkg::LOAD_LH:  result_o = {{16{half_lane[15]}}, half_lane};
                wb_pkg::LOAD_LHU: result_o = {16'd0, half_lane};
                wb_pkg::LOAD_LW:  result_o = data_rdata_i;
                wb_pkg::LOAD_LWL: result_o = lwl_data;
                wb_pkg::LOAD_LWR: result_o = lwr_data;
                // bus access without a load, e.g. a store
                default:          result_o = stage.final_res;
            endcase
        end
    end

    // decode sees the raw bus word for memory requests
    assign fwd_data_o = stage.mem_req ? data_rdata_i : stage.final_res;

endmodule

//--- hdl/wb_regfile.sv
`timescale 1ns/1ps

module wb_regfile #(
    parameter int REG_COUNT = 32
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          we_i,
    input  logic [wb_pkg::REG_NUM_W-1:0]  wnum_i,
    input  logic [wb_pkg::WORD_W-1:0]     wdata_i,
    input  logic [wb_pkg::REG_NUM_W-1:0]  rd_num_a_i,
    input  logic [wb_pkg::REG_NUM_W-1:0]  rd_num_b_i,
    output logic [wb_pkg::WORD_W-1:0]     rd_data_a_o,
    output logic [wb_pkg::WORD_W-1:0]     rd_data_b_o
);

    logic [wb_pkg::WORD_W-1:0] regs [REG_COUNT];

    ////////////////////
    // write port
    ////////////////////

    always_ff @(posedge clk) begin
        if (!rst) begin
            for (int i = 0; i < REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && wnum_i != '0) begin
            // r0 is hardwired, writes to it are dropped
            regs[wnum_i] <= wdata_i;
        end
    end

    ////////////////////
    // read ports
    ////////////////////

    // combinational, new value shows up the cycle after the write edge
    always_comb begin
        if (rd_num_a_i == '0) begin
            rd_data_a_o = '0;
        end else begin
            rd_data_a_o = regs[rd_num_a_i];
        end
    end

    always_comb begin
        if (rd_num_b_i == '0) begin
            rd_data_b_o = '0;
        end else begin
            rd_data_b_o = regs[rd_num_b_i];
        end
    end

endmodule

//--- hdl/commit_trace.sv
`timescale 1ns/1ps

module commit_trace #(
    parameter int COUNT_W = 16
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          commit_i,
    wb_stage_if.consumer                  stage,
    input  logic [wb_pkg::WORD_W-1:0]     result_i,
    output logic [wb_pkg::WORD_W-1:0]     trace_pc_o,
    output logic [3:0]                    trace_wen_o,
    output logic [wb_pkg::REG_NUM_W-1:0]  trace_wnum_o,
    output logic [wb_pkg::WORD_W-1:0]     trace_wdata_o,
    output logic [COUNT_W-1:0]            commit_count_o
);

    ////////////////////
    // trace registers
    ////////////////////

    always_ff @(posedge clk) begin
        if (!rst) begin
            trace_pc_o     <= '0;
            trace_wen_o    <= '0;
            trace_wnum_o   <= '0;
            trace_wdata_o  <= '0;
            commit_count_o <= '0;
        end else if (commit_i) begin
            trace_pc_o     <= stage.vaddr;
            // all byte enables set when the instruction has a destination
            trace_wen_o    <= {4{stage.write_num != '0}};
            trace_wnum_o   <= stage.write_num;
            trace_wdata_o  <= result_i;
            // wraps at COUNT_W
            commit_count_o <= commit_count_o + 1'b1;
        end
    end

    // commit pulse must refer to a valid stage entry
    a_commit_valid: assert property (@(posedge clk) disable iff (!rst)
        commit_i |-> stage.valid);

endmodule

//--- hdl/wb_top.sv
`timescale 1ns/1ps

module wb_top #(
    parameter int REG_COUNT = 32,
    parameter int COUNT_W   = 16
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          mem_valid_i,
    input  logic                          pipe_go_i,
    input  logic                          flush_i,
    input  logic [wb_pkg::REG_NUM_W-1:0]  mem_write_num_i,
    input  logic                          mem_req_i,
    input  wb_pkg::load_op_e              mem_load_op_i,
    input  logic [wb_pkg::WORD_W-1:0]     mem_vaddr_i,
    input  logic [wb_pkg::WORD_W-1:0]     mem_rt_data_i,
    input  logic [wb_pkg::WORD_W-1:0]     mem_final_res_i,
    input  logic [wb_pkg::WORD_W-1:0]     data_rdata_i,
    input  logic [wb_pkg::REG_NUM_W-1:0]  rd_num_a_i,
    input  logic [wb_pkg::REG_NUM_W-1:0]  rd_num_b_i,
    output logic                          allowin_o,
    output logic                          commit_o,
    output logic                          reg_we_o,
    output logic [wb_pkg::REG_NUM_W-1:0]  reg_wnum_o,
    output logic [wb_pkg::WORD_W-1:0]     reg_wdata_o,
    output logic [wb_pkg::WORD_W-1:0]     fwd_data_o,
    output logic [wb_pkg::WORD_W-1:0]     rd_data_a_o,
    output logic [wb_pkg::WORD_W-1:0]     rd_data_b_o,
    output logic [wb_pkg::WORD_W-1:0]     trace_pc_o,
    output logic [3:0]                    trace_wen_o,
    output logic [wb_pkg::REG_NUM_W-1:0]  trace_wnum_o,
    output logic [wb_pkg::WORD_W-1:0]     trace_wdata_o,
    output logic [COUNT_W-1:0]            commit_count_o
);

    logic stage_load;
    logic stage_full;

    wb_stage_if stage_bus ();

    wb_ctrl u_ctrl (
        .clk         (clk),
        .rst         (rst),
        .mem_valid_i (mem_valid_i),
        .pipe_go_i   (pipe_go_i),
        .flush_i     (flush_i),
        .allowin_o   (allowin_o),
        .load_o      (stage_load),
        .full_o      (stage_full),
        .commit_o    (commit_o)
    );

    wb_stage_reg u_stage_reg (
        .clk             (clk),
        .rst             (rst),
        .load_i          (stage_load),
        .full_i          (stage_full),
        .mem_write_num_i (mem_write_num_i),
        .mem_req_i       (mem_req_i),
        .mem_load_op_i   (mem_load_op_i),
        .mem_vaddr_i     (mem_vaddr_i),
        .mem_rt_data_i   (mem_rt_data_i),
        .mem_final_res_i (mem_final_res_i),
        .stage           (stage_bus.producer)
    );

    load_align u_load_align (
        .stage        (stage_bus.consumer),
        .data_rdata_i (data_rdata_i),
        .result_o     (reg_wdata_o),
        .fwd_data_o   (fwd_data_o)
    );

    // destination goes back to decode for hazard checks
    assign reg_wnum_o = stage_bus.write_num;
    // only place where commit meets the nonzero destination
    assign reg_we_o   = commit_o && (stage_bus.write_num != '0);

    wb_regfile #(
        .REG_COUNT (REG_COUNT)
    ) u_regfile (
        .clk         (clk),
        .rst         (rst),
        .we_i        (reg_we_o),
        .wnum_i      (reg_wnum_o),
        .wdata_i     (reg_wdata_o),
        .rd_num_a_i  (rd_num_a_i),
        .rd_num_b_i  (rd_num_b_i),
        .rd_data_a_o (rd_data_a_o),
        .rd_data_b_o (rd_data_b_o)
    );

    commit_trace #(
        .COUNT_W (COUNT_W)
    ) u_commit_trace (
        .clk            (clk),
        .rst            (rst),
        .commit_i       (commit_o),
        .stage          (stage_bus.consumer),
        .result_i       (reg_wdata_o),
        .trace_pc_o     (trace_pc_o),
        .trace_wen_o    (trace_wen_o),
        .trace_wnum_o   (trace_wnum_o),
        .trace_wdata_o  (trace_wdata_o),
        .commit_count_o (commit_count_o)
    );

endmodule

//--- sim/wb_tb_table.svh
// one row per instruction with opcode, write number, vaddr, rt data, final result,
// bus word, go-low cycles, flush flag and expected register value

// non-loads with the r0 write dropped
add_row(wb_pkg::LOAD_NONE, 5'd1, 32'h2000, RT_W, 32'hcafe0001, BUS_W, 3'd0, 1'b0, 32'hcafe0001);
add_row(wb_pkg::LOAD_NONE, 5'd0, 32'h2004, RT_W, 32'hdeadbeef, BUS_W, 3'd0, 1'b0, 32'hdeadbeef);
add_row(wb_pkg::LOAD_NONE, 5'd2, 32'h2008, RT_W, 32'h0badf00d, BUS_W, 3'd3, 1'b0, 32'h0badf00d);

// byte loads, all four lanes
add_row(wb_pkg::LOAD_LB, 5'd3, 32'h1000, RT_W, 32'h0, BUS_W, 3'd0, 1'b0, 32'hffffffd4);
add_row(wb_pkg::LOAD_LB, 5'd4, 32'h1001, RT_W, 32'h0, BUS_W, 3'd0, 1'b0, 32'h00000063);
add_row(wb_pkg::LOAD_LB, 5'd5, 32'h1002, RT_W, 32'h0, BUS_W, 3'd1, 1'b0, 32'hfffffff2);
add_row(wb_pkg::LOAD_LB, 5'd6, 32'h1003, RT_W, 32'h0, BUS_W, 3'd0, 1'b0, 32'hffffff81);
add_row(wb_pkg::LOAD_LBU, 5'd7, 32'h1010, RT_W, 32'h0, BUS_W, 3'd0, 1'b0, 32'h000000d4);
add_row(wb_pkg::LOAD_LBU, 5'd8, 32'h1011, RT_W, 32'h0, BUS_W, 3'd0, 1'b0, 32'h00000063);
add_row(wb_pkg::LOAD_LBU, 5'd9, 32'h1012, RT_W, 32'h0, BUS_W, 3'd2, 1'b0, 32'h000000f2);
add_row(wb_pkg::LOAD_LBU, 5'd10, 32'h1013, RT_W, 32'h0, BUS_W, 3'd0, 1'b0, 32'h00000081);

// halves and words
add_row(wb_pkg::LOAD_LH, 5'd11, 32'h1020, RT_W, 32'h0, BUS_W, 3'd0, 1'b0, 32'h000063d4);
add_row(wb_pkg::LOAD_LH, 5'd12, 32'h1022, RT_W, 32'h0, BUS_W, 3'd0, 1'b0, 32'hffff81f2);
add_row(wb_pkg::LOAD_LHU, 5'd13, 32'h1030, RT_W, 32'h0, BUS_W, 3'd0, 1'b0, 32'h000063d4);
add_row(wb_pkg::LOAD_LHU, 5'd14, 32'h1032, RT_W, 32'h0, BUS_W, 3'd1, 1'b0, 32'h000081f2);
add_row(wb_pkg::LOAD_LW, 5'd15, 32'h1040, RT_W, 32'h0, BUS_W, 3'd0, 1'b0, 32'h81f263d4);

// unaligned merges with rt
add_row(wb_pkg::LOAD_LWL, 5'd16, 32'h1050, RT_W, 32'h0, BUS_W, 3'd0, 1'b0, 32'hd4223344);
add_row(wb_pkg::LOAD_LWL, 5'd17, 32'h1051, RT_W, 32'h0, BUS_W, 3'd0, 1'b0, 32'h63d43344);
add_row(wb_pkg::LOAD_LWL, 5'd18, 32'h1052, RT_W, 32'h0, BUS_W, 3'd0, 1'b0, 32'hf263d444);
add_row(wb_pkg::LOAD_LWL, 5'd19, 32'h1053, RT_W, 32'h0, BUS_W, 3'd0, 1'b0, 32'h81f263d4);
add_row(wb_pkg::LOAD_LWR, 5'd20, 32'h1060, RT_W, 32'h0, BUS_W, 3'd0, 1'b0, 32'h81f263d4);
add_row(wb_pkg::LOAD_LWR, 5'd21, 32'h1061, RT_W, 32'h0, BUS_W, 3'd0, 1'b0, 32'h1181f263);
add_row(wb_pkg::LOAD_LWR, 5'd22, 32'h1062, RT_W, 32'h0, BUS_W, 3'd0, 1'b0, 32'h112281f2);
add_row(wb_pkg::LOAD_LWR, 5'd23, 32'h1063, RT_W, 32'h0, BUS_W, 3'd0, 1'b0, 32'h11223381);

// long stall then flushes that leave r1 and r3 alone
add_row(wb_pkg::LOAD_LW, 5'd24, 32'h1070, RT_W, 32'h0, BUS_W, 3'd5, 1'b0, 32'h81f263d4);
add_row(wb_pkg::LOAD_NONE, 5'd1, 32'h2010, RT_W, 32'h12345678, BUS_W, 3'd0, 1'b1, 32'h12345678);
add_row(wb_pkg::LOAD_LB, 5'd3, 32'h1081, RT_W, 32'h0, BUS_W, 3'd0, 1'b1, 32'h00000063);
add_row(wb_pkg::LOAD_NONE, 5'd25, 32'h2014, RT_W, 32'h00c0ffee, BUS_W, 3'd2, 1'b0, 32'h00c0ffee);

//--- sim/wb_tb.sv
`timescale 1ns/1ps

module wb_tb;

    localparam logic [31:0] BUS_W  = 32'h81f263d4;
    localparam logic [31:0] RT_W   = 32'h11223344;
    localparam int          N_RAND = 16;

    typedef struct packed {
        wb_pkg::load_op_e op;
        logic [4:0]       wnum;
        logic [31:0]      vaddr;
        logic [31:0]      rt;
        logic [31:0]      res;
        logic [31:0]      bus;
        logic [2:0]       gap;
        logic             flush;
        logic [31:0]      exp_val;
    } row_t;

    logic             clk;
    logic             rst;
    logic             mem_valid_i;
    logic             pipe_go_i;
    logic             flush_i;
    logic [4:0]       mem_write_num_i;
    logic             mem_req_i;
    wb_pkg::load_op_e mem_load_op_i;
    logic [31:0]      mem_vaddr_i;
    logic [31:0]      mem_rt_data_i;
    logic [31:0]      mem_final_res_i;
    logic [31:0]      data_rdata_i;
    logic [4:0]       rd_num_a_i;
    logic [4:0]       rd_num_b_i;
    logic             allowin_o;
    logic             commit_o;
    logic             reg_we_o;
    logic [4:0]       reg_wnum_o;
    logic [31:0]      reg_wdata_o;
    logic [31:0]      fwd_data_o;
    logic [31:0]      rd_data_a_o;
    logic [31:0]      rd_data_b_o;
    logic [31:0]      trace_pc_o;
    logic [3:0]       trace_wen_o;
    logic [4:0]       trace_wnum_o;
    logic [31:0]      trace_wdata_o;
    logic [15:0]      commit_count_o;

    row_t        rows [$];
    logic [31:0] reg_model [32];
    int          committed;
    int          n_checks;
    int          n_errors;
    logic        table_ready;

    wb_top #(
        .REG_COUNT (32),
        .COUNT_W   (16)
    ) wb_top_i (.*);

    always #10 clk = ~clk;

    ////////////////////
    // checking
    ////////////////////

    task automatic check_equal(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        n_checks++;
        assert (got === exp) else begin
            n_errors++;
            $display("[FAIL] %0t ns %s: got %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic print_summary();
        $display("summary: %0d checks, %0d errors", n_checks, n_errors);
    endtask

    ////////////////////
    // reference model
    ////////////////////

    // formatting rules per opcode, built lane by lane
    function automatic logic [31:0] ref_format(input wb_pkg::load_op_e op,
            input logic [31:0] vaddr, input logic [31:0] rt,
            input logic [31:0] res, input logic [31:0] bus);
        int          k;
        int          i;
        logic [7:0]  b;
        logic [15:0] h;
        logic [31:0] v;
        k = 32'(vaddr[1:0]);
        b = bus[8*k +: 8];
        h = bus[16*(k/2) +: 16];
        v = rt;
        case (op)
            wb_pkg::LOAD_LB:  v = {{24{b[7]}}, b};
            wb_pkg::LOAD_LBU: v = {24'd0, b};
            wb_pkg::LOAD_LH:  v = {{16{h[15]}}, h};
            wb_pkg::LOAD_LHU: v = {16'd0, h};
            wb_pkg::LOAD_LW:  v = bus;
            wb_pkg::LOAD_LWL: begin
                // bus byte i lands in result byte 3-k+i
                for (i = 0; i <= k; i++) begin
                    v[8*(3-k+i) +: 8] = bus[8*i +: 8];
                end
            end
            wb_pkg::LOAD_LWR: begin
                for (i = k; i < 4; i++) begin
                    v[8*(i-k) +: 8] = bus[8*i +: 8];
                end
            end
            default:          v = res;
        endcase
        return v;
    endfunction

    task automatic add_row(input wb_pkg::load_op_e op, input logic [4:0] wnum,
            input logic [31:0] vaddr, input logic [31:0] rt, input logic [31:0] res,
            input logic [31:0] bus, input logic [2:0] gap, input logic flush,
            input logic [31:0] exp_val);
        row_t r;
        r.op      = op;
        r.wnum    = wnum;
        r.vaddr   = vaddr;
        r.rt      = rt;
        r.res     = res;
        r.bus     = bus;
        r.gap     = gap;
        r.flush   = flush;
        r.exp_val = exp_val;
        rows.push_back(r);
    endtask

    task automatic build_table();
        `include "wb_tb_table.svh"
    endtask

    task automatic add_random_rows(input int n);
        int   m;
        row_t r;
        for (m = 0; m < n; m++) begin
            r.op    = wb_pkg::load_op_e'(3'($urandom_range(7, 0)));
            r.wnum  = 5'($urandom_range(31, 1));
            r.vaddr = $urandom;
            // halves and words stay aligned
            if (r.op == wb_pkg::LOAD_LH || r.op == wb_pkg::LOAD_LHU) begin
                r.vaddr[0] = 1'b0;
            end
            if (r.op == wb_pkg::LOAD_LW) begin
                r.vaddr[1:0] = 2'b00;
            end
            r.rt      = $urandom;
            r.res     = $urandom;
            r.bus     = $urandom;
            r.gap     = 3'($urandom_range(3, 0));
            r.flush   = 1'b0;
            r.exp_val = ref_format(r.op, r.vaddr, r.rt, r.res, r.bus);
            rows.push_back(r);
        end
    endtask

    ////////////////////
    // stimulus
    ////////////////////

    task automatic drive_fields(input row_t r);
        mem_valid_i     <= 1'b1;
        mem_load_op_i   <= r.op;
        mem_write_num_i <= r.wnum;
        mem_req_i       <= (r.op != wb_pkg::LOAD_NONE);
        mem_vaddr_i     <= r.vaddr;
        mem_rt_data_i   <= r.rt;
        mem_final_res_i <= r.res;
    endtask

    // one instruction through the stage, with optional stall or flush
    task automatic run_row(input row_t r);
        int          waited;
        logic [31:0] old_val;
        logic        is_load;
        is_load = (r.op != wb_pkg::LOAD_NONE);
        old_val = reg_model[r.wnum];
        @(posedge clk);
        drive_fields(r);
        data_rdata_i <= r.bus;
        rd_num_a_i   <= r.wnum;
        pipe_go_i    <= 1'b0;
        flush_i      <= 1'b0;
        @(negedge clk);
        check_equal("allowin_o", 32'(allowin_o), 32'd1);
        @(posedge clk);
        mem_valid_i <= 1'b0;
        if (r.flush) begin
            // go high too, flush must still win
            flush_i   <= 1'b1;
            pipe_go_i <= 1'b1;
            @(negedge clk);
            check_equal("commit_o", 32'(commit_o), 32'd0);
            @(posedge clk);
            flush_i   <= 1'b0;
            pipe_go_i <= 1'b0;
            @(negedge clk);
            check_equal("allowin_o", 32'(allowin_o), 32'd1);
            check_equal("rd_data_a_o", rd_data_a_o, old_val);
            check_equal("commit_count_o", 32'(commit_count_o), 32'(committed));
        end else begin
            repeat (r.gap) begin
                @(negedge clk);
                check_equal("commit_o", 32'(commit_o), 32'd0);
                check_equal("allowin_o", 32'(allowin_o), 32'd0);
                check_equal("rd_data_a_o", rd_data_a_o, old_val);
                @(posedge clk);
            end
            pipe_go_i <= 1'b1;
            waited = 0;
            @(negedge clk);
            while (!commit_o && waited < 8) begin
                @(negedge clk);
                waited++;
            end
            assert (commit_o) else begin
                n_errors++;
                $display("commit never came for the instruction at %h", r.vaddr);
            end
            check_equal("reg_wdata_o", reg_wdata_o, r.exp_val);
            check_equal("reg_wnum_o", 32'(reg_wnum_o), 32'(r.wnum));
            check_equal("reg_we_o", 32'(reg_we_o), 32'(r.wnum != 5'd0));
            check_equal("fwd_data_o", fwd_data_o, is_load ? r.bus : r.res);
            @(posedge clk);
            pipe_go_i <= 1'b0;
            if (r.wnum != 5'd0) begin
                reg_model[r.wnum] = r.exp_val;
            end
            committed++;
            @(negedge clk);
            check_equal("commit_o", 32'(commit_o), 32'd0);
            check_equal("rd_data_a_o", rd_data_a_o, reg_model[r.wnum]);
            check_equal("rd_data_b_o", rd_data_b_o, 32'd0);
            check_equal("trace_pc_o", trace_pc_o, r.vaddr);
            check_equal("trace_wnum_o", 32'(trace_wnum_o), 32'(r.wnum));
            check_equal("trace_wdata_o", trace_wdata_o, r.exp_val);
            check_equal("trace_wen_o", 32'(trace_wen_o), (r.wnum != 5'd0) ? 32'hf : 32'h0);
            check_equal("commit_count_o", 32'(commit_count_o), 32'(committed));
        end
    endtask

    // go held high, one commit per cycle
    task automatic run_burst(input int first, input int n);
        int   j;
        row_t prev;
        for (j = 0; j <= n; j++) begin
            @(posedge clk);
            pipe_go_i <= 1'b1;
            flush_i   <= 1'b0;
            if (j < n) begin
                drive_fields(rows[first + j]);
            end else begin
                mem_valid_i <= 1'b0;
            end
            if (j > 0) begin
                prev = rows[first + j - 1];
                data_rdata_i <= prev.bus;
            end
            @(negedge clk);
            if (j > 1) begin
                check_equal("trace_wdata_o", trace_wdata_o, rows[first + j - 2].exp_val);
            end
            if (j > 0) begin
                check_equal("commit_o", 32'(commit_o), 32'd1);
                check_equal("reg_wdata_o", reg_wdata_o, prev.exp_val);
                check_equal("commit_count_o", 32'(commit_count_o), 32'(committed));
                reg_model[prev.wnum] = prev.exp_val;
                committed++;
            end
        end
        @(posedge clk);
        pipe_go_i <= 1'b0;
    endtask

    task automatic sweep_regfile();
        int         n;
        logic [4:0] num;
        for (n = 0; n < 32; n++) begin
            num = 5'(n);
            @(posedge clk);
            rd_num_a_i <= num;
            rd_num_b_i <= ~num;
            @(negedge clk);
            check_equal("rd_data_a_o", rd_data_a_o, reg_model[num]);
            check_equal("rd_data_b_o", rd_data_b_o, reg_model[~num]);
        end
    endtask

    ////////////////////
    // main sequence
    ////////////////////

    initial begin
        int n_fixed;
        int idx;
        clk = 1'b0;
        rst = 1'b0;
        mem_valid_i = 1'b0;
        pipe_go_i = 1'b0;
        flush_i = 1'b0;
        mem_write_num_i = 5'd0;
        mem_req_i = 1'b0;
        mem_load_op_i = wb_pkg::LOAD_NONE;
        mem_vaddr_i = 32'd0;
        mem_rt_data_i = 32'd0;
        mem_final_res_i = 32'd0;
        data_rdata_i = 32'd0;
        rd_num_a_i = 5'd0;
        rd_num_b_i = 5'd0;
        committed = 0;
        n_checks = 0;
        n_errors = 0;
        table_ready = 1'b0;
        for (idx = 0; idx < 32; idx++) begin
            reg_model[idx] = 32'd0;
        end
        void'($urandom(32'hd5a7edfa));
        build_table();
        n_fixed = rows.size();
        add_random_rows(N_RAND);
        table_ready = 1'b1;

        repeat (4) @(posedge clk);
        rst <= 1'b1;
        @(negedge clk);
        check_equal("allowin_o", 32'(allowin_o), 32'd1);
        check_equal("commit_o", 32'(commit_o), 32'd0);
        check_equal("reg_we_o", 32'(reg_we_o), 32'd0);
        check_equal("trace_pc_o", trace_pc_o, 32'd0);
        check_equal("trace_wdata_o", trace_wdata_o, 32'd0);
        check_equal("commit_count_o", 32'(commit_count_o), 32'd0);

        for (idx = 0; idx < n_fixed + N_RAND / 2; idx++) begin
            run_row(rows[idx]);
        end
        run_burst(n_fixed + N_RAND / 2, N_RAND / 2);
        sweep_regfile();
        check_equal("commit_count_o", 32'(commit_count_o), 32'(committed));

        print_summary();
        if (n_errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

    // budget of 40 cycles per table row
    initial begin
        int limit_ns;
        wait (table_ready);
        limit_ns = rows.size() * 40 * 20;
        #(limit_ns);
        $display("watchdog expired after %0d ns, the run did not finish", limit_ns);
        print_summary();
        $display("Errors found");
        $finish;
    end

endmodule

//--- files.f
+incdir+sim
hdl/wb_pkg.sv
hdl/wb_stage_if.sv
hdl/wb_ctrl.sv
hdl/wb_stage_reg.sv
hdl/load_align.sv
hdl/wb_regfile.sv
hdl/commit_trace.sv
hdl/wb_top.sv
sim/wb_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= wb_tb
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  := No errors

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
